// ==== flist.f ====
+incdir+include
hw/alu_pkg.sv
hw/cluster_pkg.sv
hw/wb_cmd_regs.sv
hw/ex_lane.sv
hw/result_collector.sv
hw/alu_cluster_top.sv
sim/tb_alu_cluster.sv

// ==== include/alu_ref_model.svh ====
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Expected lane result for one command, computed the long way
function automatic logic [alu_pkg::XLEN-1:0] alu_ref_model(
  input logic [3:0]  op,
  input logic        src1,
  input logic        src2,
  input logic [31:0] rs1,
  input logic [31:0] rs2,
  input logic [31:0] imm,
  input logic [31:0] pc
);
  logic [31:0]        a;
  logic [31:0]        b;
  logic signed [63:0] p_ss;
  logic [63:0]        p_uu;
  logic signed [63:0] p_su;
  a    = (src1 == alu_pkg::SRC1_PC) ? pc : rs1;
  b    = (src2 == alu_pkg::SRC2_IMM) ? imm : rs2;
  p_ss = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
  p_uu = {32'b0, a} * {32'b0, b};
  p_su = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});  // Source 2 unsigned
  case (op)
    alu_pkg::ADD:    return a + b;
    alu_pkg::SUB:    return a - b;
    alu_pkg::SLL:    return a << b[4:0];
    alu_pkg::SRL:    return a >> b[4:0];
    alu_pkg::SRA:    return $signed(a) >>> b[4:0];
    alu_pkg::SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    alu_pkg::SLTU:   return (a < b) ? 32'd1 : 32'd0;
    alu_pkg::OR:     return a | b;
    alu_pkg::XOR:    return a ^ b;
    alu_pkg::AND:    return a & b;
    alu_pkg::MUL:    return p_ss[31:0];
    alu_pkg::MULH:   return p_ss[63:32];
    alu_pkg::MULHU:  return p_uu[63:32];
    alu_pkg::MULHSU: return p_su[63:32];
    alu_pkg::LINK:   return pc + 32'd4;
    default:         return '0;
  endcase
endfunction

`endif

// ==== sim/tb_alu_cluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_alu_cluster;

  import alu_pkg::*;
  import cluster_pkg::*;

  `include "alu_ref_model.svh"

  localparam int MAX_OPS        = 80;
  localparam int CYCLES_PER_OP  = 30;
  localparam int TIMEOUT_CYCLES = 2 * MAX_OPS * CYCLES_PER_OP + 200;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat;
  logic [31:0] wb_rdat;
  logic        wb_ack;

  logic [31:0] lfsr_state;
  logic [31:0] cur_rs1;
  logic [31:0] cur_rs2;
  logic [31:0] cur_imm;
  logic [31:0] cur_pc;
  logic [31:0] exp_val [16];  // Keyed by tag
  logic [15:0] pending;
  logic [31:0] rd_word;
  logic        acked;
  int          err_cnt;
  int          err_mark;
  int          check_cnt;
  int          test_cnt;
  int          cycle_cnt;

  alu_cluster_top dut0 (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, run stopped after %0d cycles", cycle_cnt);
    $display("TESTS FAILED");
    $finish;
  end

  a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> wb_stb)
    else begin
      $display("ack was high while stb was low");
      err_cnt++;
    end

  a_ack_drops: assert property (@(posedge clk) disable iff (!rst_n) !wb_stb |=> !wb_ack)
    else begin
      $display("ack stayed high after stb dropped");
      err_cnt++;
    end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] cmd_word(input logic [3:0] op, input logic s1,
                                           input logic s2, input logic [3:0] tag);
    return {20'b0, tag, 2'b0, s2, s1, op};
  endfunction

  // One classic cycle, called and left 1 ns after a rising edge
  task automatic run_access(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                            input int max_wait, output logic ok, output logic [31:0] rdata);
    int waited;
    waited = 0;
    ok     = 1'b0;
    rdata  = '0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = wdata;
    while (!ok && (max_wait == 0 || waited < max_wait)) begin
      @(posedge clk);
      #1;
      waited++;
      ok = wb_ack;
    end
    if (ok) begin
      rdata = wb_rdat;
      @(posedge clk);  // Stb held through the ack cycle
      #1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [31:0] data);
    logic        ok;
    logic [31:0] unused;
    run_access(1'b1, adr, data, 0, ok, unused);
  endtask

  task automatic read_reg(input logic [7:0] adr, output logic [31:0] data);
    logic ok;
    run_access(1'b0, adr, '0, 0, ok, data);
    @(posedge clk);  // Bus idle for one cycle
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    assert (actual === expected) else begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic load_operands();
    rand_word(cur_rs1);
    rand_word(cur_rs2);
    rand_word(cur_imm);
    rand_word(cur_pc);
    write_reg(ADDR_RS1, cur_rs1);
    write_reg(ADDR_RS2, cur_rs2);
    write_reg(ADDR_IMM, cur_imm);
    write_reg(ADDR_PC, cur_pc);
  endtask

  task automatic expect_cmd(input logic [3:0] op, input logic s1, input logic s2,
                            input logic [3:0] tag);
    exp_val[tag] = alu_ref_model(op, s1, s2, cur_rs1, cur_rs2, cur_imm, cur_pc);
    pending[tag] = 1'b1;
  endtask

  task automatic send_cmd(input logic [3:0] op, input logic s1, input logic s2,
                          input logic [3:0] tag);
    expect_cmd(op, s1, s2, tag);
    write_reg(ADDR_CMD, cmd_word(op, s1, s2, tag));
  endtask

  // Poll the head tag, then pop and compare
  task automatic collect_result(input string name);
    logic [31:0] word;
    logic [3:0]  tag;
    word = '0;
    while (!word[31]) read_reg(ADDR_RES_TAG, word);
    tag = word[3:0];
    check_cnt++;
    assert (pending[tag]) else begin
      $display("%s: tag %0d came back with no command pending", name, tag);
      err_cnt++;
    end
    read_reg(ADDR_RES_DATA, word);
    check_value(name, exp_val[tag], word);
    pending[tag] = 1'b0;
  endtask

  task automatic wait_status(input logic [31:0] expected, input string name);
    logic [31:0] word;
    int          tries;
    tries = 0;
    read_reg(ADDR_STATUS, word);
    while (word !== expected && tries < 40) begin
      read_reg(ADDR_STATUS, word);
      tries++;
    end
    check_value(name, expected, word);
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_mark) ? "ok" : "errors");
    err_mark = err_cnt;
  endtask

  initial begin
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat     = '0;
    lfsr_state = 32'd93320;
    pending    = '0;
    err_cnt    = 0;
    err_mark   = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    read_reg(ADDR_STATUS, rd_word);
    check_value("reset", 32'h0, rd_word);
    read_reg(ADDR_RES_TAG, rd_word);
    check_value("reset", 32'h0, {31'b0, rd_word[31]});  // Tag bits undefined when empty
    end_test("reset");

    // Opcode 15 lies outside the enum and must return zero
    for (int op = 0; op < 16; op++) begin
      for (int sel = 0; sel < 4; sel++) begin
        load_operands();
        send_cmd(4'(op), sel[0], sel[1], 4'(op));
        collect_result("opcodes");
      end
    end
    end_test("opcodes");

    load_operands();
    send_cmd(MUL, 1'b0, 1'b0, 4'd0);
    send_cmd(MULH, 1'b1, 1'b1, 4'd1);
    send_cmd(MULHU, 1'b0, 1'b1, 4'd2);
    send_cmd(MULHSU, 1'b1, 1'b0, 4'd3);
    repeat (4) collect_result("multiplies");
    end_test("multiplies");

    for (int i = 0; i < 12; i++) begin
      load_operands();
      send_cmd(4'(i % 15), i[0], i[1], 4'(i));
    end
    wait_status(32'h0000_0F08, "backpressure");
    load_operands();
    expect_cmd(ADD, 1'b1, 1'b1, 4'd12);
    run_access(1'b1, ADDR_CMD, cmd_word(ADD, 1'b1, 1'b1, 4'd12), 20, acked, rd_word);
    check_cnt++;
    assert (!acked) else begin
      $display("backpressure: CMD write acked while every lane was busy");
      err_cnt++;
    end
    collect_result("backpressure");
    write_reg(ADDR_CMD, cmd_word(ADD, 1'b1, 1'b1, 4'd12));
    repeat (12) collect_result("backpressure");
    end_test("backpressure");

    read_reg(ADDR_RES_DATA, rd_word);
    check_value("empty_read", 32'h0, rd_word);
    read_reg(ADDR_STATUS, rd_word);
    check_value("empty_read", 32'h0, rd_word);
    end_test("empty_read");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/alu_cluster_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_cluster_top (
  input  wire logic                              clk_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              wb_cyc_i,
  input  wire logic                              wb_stb_i,
  input  wire logic                              wb_we_i,
  input  wire logic [cluster_pkg::ADR_W-1:0]     wb_adr_i,
  input  wire logic [alu_pkg::XLEN-1:0]          wb_dat_i,
  output logic      [alu_pkg::XLEN-1:0]          wb_dat_o,
  output logic                                   wb_ack_o
);

  import alu_pkg::*;
  import cluster_pkg::*;

  logic [NUM_LANES-1:0]       issue;
  logic [NUM_LANES-1:0]       lane_busy;
  logic [NUM_LANES-1:0]       lane_done;
  logic [NUM_LANES-1:0]       grant;
  logic [NUM_LANES*XLEN-1:0]  lane_result;
  logic [NUM_LANES*TAG_W-1:0] lane_tag;
  logic [XLEN-1:0]            rs1;
  logic [XLEN-1:0]            rs2;
  logic [XLEN-1:0]            imm;
  logic [XLEN-1:0]            pc;
  alu_op_e                    op;
  src1_sel_e                  src1;
  src2_sel_e                  src2;
  logic [TAG_W-1:0]           tag;
  logic [XLEN-1:0]            res_data;
  logic [TAG_W-1:0]           res_tag;
  logic                       fifo_empty;
  logic [CNT_W-1:0]           fifo_count;
  logic                       pop;

  wb_cmd_regs u_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .lane_busy_i  (lane_busy),
    .fifo_count_i (fifo_count),
    .res_data_i   (res_data),
    .res_tag_i    (res_tag),
    .fifo_empty_i (fifo_empty),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .issue_o      (issue),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .imm_o        (imm),
    .pc_o         (pc),
    .op_o         (op),
    .src1_o       (src1),
    .src2_o       (src2),
    .tag_o        (tag),
    .pop_o        (pop)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    ex_lane u_lane (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .issue_i  (issue[g]),
      .rs1_i    (rs1),
      .rs2_i    (rs2),
      .imm_i    (imm),
      .pc_i     (pc),
      .op_i     (op),
      .src1_i   (src1),
      .src2_i   (src2),
      .tag_i    (tag),
      .grant_i  (grant[g]),
      .busy_o   (lane_busy[g]),
      .done_o   (lane_done[g]),
      .result_o (lane_result[g*XLEN +: XLEN]),
      .tag_o    (lane_tag[g*TAG_W +: TAG_W])
    );
  end

  result_collector u_collector (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .done_i       (lane_done),
    .result_i     (lane_result),
    .tag_i        (lane_tag),
    .pop_i        (pop),
    .grant_o      (grant),
    .res_data_o   (res_data),
    .res_tag_o    (res_tag),
    .fifo_empty_o (fifo_empty),
    .fifo_count_o (fifo_count)
  );

endmodule

`default_nettype wire

// ==== hw/result_collector.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_collector (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  input  wire logic  [cluster_pkg::NUM_LANES-1:0]                    done_i,
  input  wire logic  [cluster_pkg::NUM_LANES*alu_pkg::XLEN-1:0]      result_i,
  input  wire logic  [cluster_pkg::NUM_LANES*cluster_pkg::TAG_W-1:0] tag_i,
  input  wire logic  pop_i,

  output logic       [cluster_pkg::NUM_LANES-1:0]                    grant_o,
  output logic       [alu_pkg::XLEN-1:0]                             res_data_o,
  output logic       [cluster_pkg::TAG_W-1:0]                        res_tag_o,
  output logic                                                       fifo_empty_o,
  output logic       [cluster_pkg::CNT_W-1:0]                        fifo_count_o
);

  import alu_pkg::*;
  import cluster_pkg::*;

  logic [XLEN-1:0]  data_mem [FIFO_DEPTH];
  logic [TAG_W-1:0] tag_mem  [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             push;
  logic [XLEN-1:0]  push_data;
  logic [TAG_W-1:0] push_tag;

  assign full    = (fifo_count_o == CNT_W'(FIFO_DEPTH));
  assign grant_o = full ? '0 : (done_i & (~done_i + 1'b1));  // Lowest done lane
  assign push    = |grant_o;

  always_comb begin
    push_data = '0;
    push_tag  = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (grant_o[i]) begin
        push_data = result_i[i*XLEN +: XLEN];
        push_tag  = tag_i[i*TAG_W +: TAG_W];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fifo_count_o <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (pop_i) rd_ptr <= rd_ptr + 1'b1;
      fifo_count_o <= fifo_count_o + CNT_W'(push) - CNT_W'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr] <= push_data;
      tag_mem[wr_ptr]  <= push_tag;
    end
  end

  assign res_data_o   = data_mem[rd_ptr];
  assign res_tag_o    = tag_mem[rd_ptr];
  assign fifo_empty_o = (fifo_count_o == '0);

  a_count_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo_count_o <= CNT_W'(FIFO_DEPTH));

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !fifo_empty_o);

endmodule

`default_nettype wire

// ==== hw/ex_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_lane (
  input  wire logic                                clk_i,
  input  wire logic                                rst_n_i,
  input  wire logic                                issue_i,
  input  wire logic         [alu_pkg::XLEN-1:0]    rs1_i,
  input  wire logic         [alu_pkg::XLEN-1:0]    rs2_i,
  input  wire logic         [alu_pkg::XLEN-1:0]    imm_i,
  input  wire logic         [alu_pkg::XLEN-1:0]    pc_i,
  input  wire alu_pkg::alu_op_e                    op_i,
  input  wire alu_pkg::src1_sel_e                  src1_i,
  input  wire alu_pkg::src2_sel_e                  src2_i,
  input  wire logic         [cluster_pkg::TAG_W-1:0] tag_i,
  input  wire logic                                grant_i,

  output logic                                     busy_o,
  output logic                                     done_o,
  output logic              [alu_pkg::XLEN-1:0]    result_o,
  output logic              [cluster_pkg::TAG_W-1:0] tag_o
);

  import alu_pkg::*;
  import cluster_pkg::*;

  logic [XLEN-1:0]           rs1_q;
  logic [XLEN-1:0]           rs2_q;
  logic [XLEN-1:0]           imm_q;
  logic [XLEN-1:0]           pc_q;
  alu_op_e                   op_q;
  src1_sel_e                 src1_q;
  src2_sel_e                 src2_q;
  logic [MUL_CNT_W-1:0]      cnt_q;
  logic [XLEN-1:0]           alu_in1;
  logic [XLEN-1:0]           alu_in2;
  logic [XLEN-1:0]           lane_res;
  logic                      a_signed;
  logic                      b_signed;
  logic signed [XLEN:0]      mul_a;
  logic signed [XLEN:0]      mul_b;
  logic signed [2*XLEN-1:0]  product;
  logic [2*XLEN-1:0]         prod_q;

  function automatic logic is_mul_op(input alu_op_e op);
    return op inside {MUL, MULH, MULHU, MULHSU};
  endfunction

  assign alu_in1 = (src1_q == SRC1_PC) ? pc_q : rs1_q;
  assign alu_in2 = (src2_q == SRC2_IMM) ? imm_q : rs2_q;

  // One 33x33 signed multiplier covers all four forms
  assign a_signed = op_q inside {MUL, MULH, MULHSU};
  assign b_signed = op_q inside {MUL, MULH};
  assign mul_a    = {a_signed & alu_in1[XLEN-1], alu_in1};
  assign mul_b    = {b_signed & alu_in2[XLEN-1], alu_in2};
  assign product  = mul_a * mul_b;

  always_comb begin
    case (op_q)
      ADD:    lane_res = alu_in1 + alu_in2;
      SUB:    lane_res = alu_in1 - alu_in2;
      SLL:    lane_res = alu_in1 << alu_in2[4:0];
      SRL:    lane_res = alu_in1 >> alu_in2[4:0];
      SRA:    lane_res = $signed(alu_in1) >>> alu_in2[4:0];
      SLT:    lane_res = {{(XLEN-1){1'b0}}, $signed(alu_in1) < $signed(alu_in2)};
      SLTU:   lane_res = {{(XLEN-1){1'b0}}, alu_in1 < alu_in2};
      OR:     lane_res = alu_in1 | alu_in2;
      XOR:    lane_res = alu_in1 ^ alu_in2;
      AND:    lane_res = alu_in1 & alu_in2;
      MUL:    lane_res = prod_q[XLEN-1:0];
      MULH,
      MULHU,
      MULHSU: lane_res = prod_q[2*XLEN-1:XLEN];  // High half
      LINK:   lane_res = pc_q + XLEN'(4);
      default: lane_res = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      cnt_q  <= '0;
    end else if (issue_i) begin
      busy_o <= 1'b1;
      done_o <= 1'b0;
      cnt_q  <= is_mul_op(op_i) ? MUL_CNT_W'(MUL_LATENCY - 1) : '0;
    end else if (grant_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
    end else if (busy_o && !done_o) begin
      if (cnt_q == '0) done_o <= 1'b1;
      else cnt_q <= cnt_q - 1'b1;
    end
  end

  // Command latch, product pipeline and held result
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      rs1_q  <= rs1_i;
      rs2_q  <= rs2_i;
      imm_q  <= imm_i;
      pc_q   <= pc_i;
      op_q   <= op_i;
      src1_q <= src1_i;
      src2_q <= src2_i;
      tag_o  <= tag_i;
    end
    if (busy_o && !done_o) begin
      prod_q <= product;
      if (cnt_q == '0) result_o <= lane_res;
    end
  end

  a_no_issue_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_i |-> !busy_o);

  a_grant_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    grant_i |-> done_o);

endmodule

`default_nettype wire

// ==== hw/wb_cmd_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_cmd_regs (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_n_i,
  input  wire logic                                      wb_cyc_i,
  input  wire logic                                      wb_stb_i,
  input  wire logic                                      wb_we_i,
  input  wire logic           [cluster_pkg::ADR_W-1:0]   wb_adr_i,
  input  wire logic           [alu_pkg::XLEN-1:0]        wb_dat_i,
  input  wire logic           [cluster_pkg::NUM_LANES-1:0] lane_busy_i,
  input  wire logic           [cluster_pkg::CNT_W-1:0]   fifo_count_i,
  input  wire logic           [alu_pkg::XLEN-1:0]        res_data_i,
  input  wire logic           [cluster_pkg::TAG_W-1:0]   res_tag_i,
  input  wire logic                                      fifo_empty_i,

  output logic                [alu_pkg::XLEN-1:0]        wb_dat_o,
  output logic                                           wb_ack_o,
  output logic                [cluster_pkg::NUM_LANES-1:0] issue_o,
  output logic                [alu_pkg::XLEN-1:0]        rs1_o,
  output logic                [alu_pkg::XLEN-1:0]        rs2_o,
  output logic                [alu_pkg::XLEN-1:0]        imm_o,
  output logic                [alu_pkg::XLEN-1:0]        pc_o,
  output alu_pkg::alu_op_e                               op_o,
  output alu_pkg::src1_sel_e                             src1_o,
  output alu_pkg::src2_sel_e                             src2_o,
  output logic                [cluster_pkg::TAG_W-1:0]   tag_o,
  output logic                                           pop_o
);

  import alu_pkg::*;
  import cluster_pkg::*;

  logic                 req;
  logic                 cmd_wr;
  logic                 go;
  logic [NUM_LANES-1:0] free_lanes;
  logic [NUM_LANES-1:0] pick;
  logic [XLEN-1:0]      rd_data;

  assign req        = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign cmd_wr     = wb_we_i & (wb_adr_i == ADDR_CMD);
  assign free_lanes = ~lane_busy_i & ~issue_o;  // Lane in flight not yet busy
  assign pick       = free_lanes & (~free_lanes + 1'b1);

  // CMD writes wait for a free lane
  assign go    = req & (~cmd_wr | (|free_lanes));
  assign pop_o = go & ~wb_we_i & (wb_adr_i == ADDR_RES_DATA) & ~fifo_empty_i;

  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      ADDR_RS1: rd_data = rs1_o;
      ADDR_RS2: rd_data = rs2_o;
      ADDR_IMM: rd_data = imm_o;
      ADDR_PC:  rd_data = pc_o;
      ADDR_STATUS: begin
        rd_data[CNT_W-1:0]                  = fifo_count_i;
        rd_data[STAT_BUSY_LSB +: NUM_LANES] = lane_busy_i;
      end
      ADDR_RES_TAG: begin
        rd_data[RES_VALID_BIT] = ~fifo_empty_i;
        rd_data[TAG_W-1:0]     = res_tag_i;
      end
      ADDR_RES_DATA: begin
        if (!fifo_empty_i) rd_data = res_data_i;  // Empty FIFO reads zero
      end
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
      issue_o  <= '0;
    end else begin
      wb_ack_o <= go;
      issue_o  <= (go && cmd_wr) ? pick : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (go && wb_we_i) begin
      case (wb_adr_i)
        ADDR_RS1: rs1_o <= wb_dat_i;
        ADDR_RS2: rs2_o <= wb_dat_i;
        ADDR_IMM: imm_o <= wb_dat_i;
        ADDR_PC:  pc_o  <= wb_dat_i;
        ADDR_CMD: begin
          op_o   <= alu_op_e'(wb_dat_i[OP_W-1:0]);
          src1_o <= src1_sel_e'(wb_dat_i[CMD_SRC1_BIT]);
          src2_o <= src2_sel_e'(wb_dat_i[CMD_SRC2_BIT]);
          tag_o  <= wb_dat_i[CMD_TAG_LSB +: TAG_W];
        end
        default: ;
      endcase
    end
    if (go && !wb_we_i) wb_dat_o <= rd_data;
  end

  a_ack_with_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |-> wb_stb_i);

  a_issue_idle_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(issue_o) && ((issue_o & lane_busy_i) == '0));

endmodule

`default_nettype wire

// ==== hw/cluster_pkg.sv ====
`default_nettype none

package cluster_pkg;

  localparam int NUM_LANES  = 4;
  localparam int TAG_W      = 4;
  localparam int FIFO_DEPTH = 8;  // Power of two
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = PTR_W + 1;
  localparam int ADR_W      = 8;

  // Byte offsets of the register map
  localparam logic [ADR_W-1:0] ADDR_RS1      = 8'h00;
  localparam logic [ADR_W-1:0] ADDR_RS2      = 8'h04;
  localparam logic [ADR_W-1:0] ADDR_IMM      = 8'h08;
  localparam logic [ADR_W-1:0] ADDR_PC       = 8'h0C;
  localparam logic [ADR_W-1:0] ADDR_CMD      = 8'h10;
  localparam logic [ADR_W-1:0] ADDR_STATUS   = 8'h14;
  localparam logic [ADR_W-1:0] ADDR_RES_TAG  = 8'h18;
  localparam logic [ADR_W-1:0] ADDR_RES_DATA = 8'h1C;  // Read pops

  // Field positions
  localparam int CMD_SRC1_BIT  = 4;
  localparam int CMD_SRC2_BIT  = 5;
  localparam int CMD_TAG_LSB   = 8;
  localparam int STAT_BUSY_LSB = 8;
  localparam int RES_VALID_BIT = 31;

endpackage

`default_nettype wire

// ==== hw/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  localparam int XLEN        = 32;
  localparam int OP_W        = 4;
  localparam int MUL_LATENCY = 4;  // Issue edge to done edge
  localparam int MUL_CNT_W   = $clog2(MUL_LATENCY);

  // Encoded opcodes, 15 is left unused
  typedef enum logic [OP_W-1:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SRL    = 4'd3,
    SRA    = 4'd4,
    SLT    = 4'd5,
    SLTU   = 4'd6,
    OR     = 4'd7,
    XOR    = 4'd8,
    AND    = 4'd9,
    MUL    = 4'd10,
    MULH   = 4'd11,
    MULHU  = 4'd12,
    MULHSU = 4'd13,
    LINK   = 4'd14
  } alu_op_e;

  typedef enum logic {
    SRC1_REG = 1'b0,
    SRC1_PC  = 1'b1
  } src1_sel_e;

  typedef enum logic {
    SRC2_REG = 1'b0,
    SRC2_IMM = 1'b1
  } src2_sel_e;

endpackage

`default_nettype wire
